// File: sources.f
i2c_pkg.sv
i2c_scl_timer.sv
i2c_byte_shifter.sv
i2c_master_fsm.sv
i2c_csr.sv
i2c_master_top.sv
tb_i2c_slave_model.sv
tb_i2c_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_i2c_master -f sources.f

# The testbench prints its verdict, the log decides the exit status
./obj_dir/Vtb_i2c_master | tee "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "Simulation ended without a verdict, see $LOG"
    exit 1
fi
echo "Simulation passed"

// File: tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master import i2c_pkg::*; ();

    localparam int          DIV_W        = 16;
    localparam int          SCL_CYCLES   = 8;                   // Divider 4, two halves
    localparam int          XFER_CYCLES  = 50 * SCL_CYCLES;     // Upper bound per transfer
    localparam int          WATCHDOG_NS  = 6 * XFER_CYCLES * 100 + 20000;
    localparam logic [6:0]  SLAVE_ADDR   = 7'h50;
    localparam logic [31:0] READ_DATA    = 32'hA53C_960F;

    logic        i_clk;
    logic        i_nrst;
    logic        i_req_valid;
    logic        o_req_ready;
    reg_req_t    i_req;
    logic        o_resp_valid;
    logic        i_resp_ready;
    reg_resp_t   o_resp;
    logic        o_scl, o_sda, o_sda_oe, o_irq, o_nreset;
    logic        sda_bus;
    logic        slave_sda;
    logic [3:0]  wr_count, ack_count, ack_bits;
    logic [31:0] wr_data;
    int          mismatch_count = 0;
    int          failure_count  = 0;
    integer      seed = 32'ha40f;

    // Open drain bus, released master reads as high
    assign sda_bus = (o_sda_oe ? o_sda : 1'b1) & slave_sda;

    i2c_master_top #(.DIV_W(DIV_W)) uut (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req        (i_req),
        .o_resp_valid (o_resp_valid),
        .i_resp_ready (i_resp_ready),
        .o_resp       (o_resp),
        .o_scl        (o_scl),
        .o_sda        (o_sda),
        .o_sda_oe     (o_sda_oe),
        .i_sda        (sda_bus),
        .o_irq        (o_irq),
        .o_nreset     (o_nreset)
    );

    tb_i2c_slave_model #(.SLAVE_ADDR(SLAVE_ADDR), .READ_DATA(READ_DATA)) slave (
        .i_clk       (i_clk),
        .i_scl       (o_scl),
        .i_sda       (sda_bus),
        .o_sda       (slave_sda),
        .o_wr_count  (wr_count),
        .o_wr_data   (wr_data),
        .o_ack_count (ack_count),
        .o_ack_bits  (ack_bits)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the simulation hung", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        mismatch_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        failure_count++;
    endtask

    function automatic logic [31:0] addr_word(input logic rnw, input logic [3:0] count,
                                              input logic [6:0] addr);
        return {rnw, 11'd0, count, 9'd0, addr};
    endfunction

    // One request, response expected on the falling edge after acceptance
    task automatic bus_access(input logic [1:0] addr, input logic wr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(negedge i_clk);
        i_req_valid = 1'b1;
        i_req       = '{addr: addr, write: wr, wdata: wdata};
        while (!o_req_ready && waited < 20) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_req_ready) begin
            note_failure("request never accepted, o_req_ready stuck low");
            i_req_valid = 1'b0;
        end else begin
            @(negedge i_clk);
            i_req_valid = 1'b0;
            if (!o_resp_valid) begin
                note_failure("no response one cycle after the request");
            end else begin
                rdata = o_resp.rdata;
                if (o_resp.err !== 1'b0) begin
                    flag_mismatch("response err set");
                end
            end
        end
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, 1'b1, data, unused);
    endtask

    task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
        bus_access(addr, 1'b0, 32'h0, data);
    endtask

    task automatic wait_transfer_end();
        int cycles;
        cycles = 0;
        while (o_irq !== 1'b1 && cycles < XFER_CYCLES) begin
            @(negedge i_clk);
            cycles++;
        end
        if (o_irq !== 1'b1) begin
            note_failure("transfer did not finish, o_irq never rose");
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] val, got;
        if (o_scl !== 1'b1 || o_sda !== 1'b1 || o_sda_oe !== 1'b1) begin
            flag_mismatch("bus pins not idle high after reset");
        end
        if (o_irq !== 1'b0 || o_nreset !== 1'b0) begin
            flag_mismatch("o_irq or o_nreset not low after reset");
        end
        if (o_req_ready !== 1'b1 || o_resp_valid !== 1'b0) begin
            flag_mismatch("host handshake not idle after reset");
        end
        val = $random(seed);
        reg_write(REG_SCLDIV, val);
        reg_read(REG_SCLDIV, got);
        if (got !== val) begin
            flag_mismatch($sformatf("REG_SCLDIV read %h, expected %h", got, val));
        end
        reg_write(REG_SCLDIV, 32'h0001_0004);    // Setup 1, divider 4
    endtask

    task automatic test_backpressure();
        logic [31:0] pay, got;
        pay = $random(seed);
        @(negedge i_clk);
        i_resp_ready = 1'b0;
        i_req_valid  = 1'b1;
        i_req        = '{addr: REG_SCLDIV, write: 1'b0, wdata: 32'h0};
        @(negedge i_clk);
        i_req = '{addr: REG_PAYLOAD, write: 1'b1, wdata: pay};   // Held while stalled
        repeat (5) begin
            if (o_resp_valid !== 1'b1 || o_resp.rdata !== 32'h0001_0004) begin
                flag_mismatch("stalled response not held stable");
            end
            if (o_req_ready !== 1'b0) begin
                flag_mismatch("o_req_ready high with a response pending");
            end
            @(negedge i_clk);
        end
        i_resp_ready = 1'b1;
        @(negedge i_clk);
        i_req_valid = 1'b0;
        if (o_resp_valid !== 1'b1) begin
            note_failure("queued write got no response after the stall");
        end
        reg_read(REG_PAYLOAD, got);
        if (got !== pay) begin
            flag_mismatch($sformatf("payload read %h, expected %h", got, pay));
        end
    endtask

    task automatic test_write_transfer();
        logic [31:0] ctrl;
        reg_write(REG_PAYLOAD, 32'h0000_C37E);
        reg_write(REG_CTRL, 32'h0000_1000);        // ie
        reg_write(REG_ADDR, addr_word(1'b0, 4'd2, SLAVE_ADDR));
        wait_transfer_end();
        if (wr_count !== 4'd2 || wr_data[15:0] !== 16'hC37E) begin
            flag_mismatch($sformatf("slave got %0d bytes %h, expected 7E then C3",
                                    wr_count, wr_data[15:0]));
        end
        reg_read(REG_CTRL, ctrl);
        if (ctrl[3:0] !== ST_IDLE || ctrl[9] !== 1'b0 || ctrl[10] !== 1'b0) begin
            flag_mismatch($sformatf("write status %h, expected idle without errors", ctrl));
        end
        if (ctrl[13] !== 1'b1) begin
            flag_mismatch("irq bit not set after write transfer");
        end
        if (o_irq !== 1'b0) begin
            flag_mismatch("o_irq not cleared by REG_CTRL read");
        end
    endtask

    task automatic test_read_transfer();
        logic [31:0] pay, ctrl;
        reg_write(REG_ADDR, addr_word(1'b1, 4'd3, SLAVE_ADDR));
        wait_transfer_end();
        reg_read(REG_PAYLOAD, pay);
        if (pay[23:0] !== READ_DATA[31:8]) begin
            flag_mismatch($sformatf("read payload %h, expected %h", pay[23:0], READ_DATA[31:8]));
        end
        if (ack_count !== 4'd3 || ack_bits[2:0] !== 3'b100) begin
            flag_mismatch($sformatf("master acks %b over %0d bytes, expected ACK ACK NACK",
                                    ack_bits[2:0], ack_count));
        end
        reg_read(REG_CTRL, ctrl);
        if (ctrl[3:0] !== ST_IDLE || ctrl[10:9] !== 2'b00) begin
            flag_mismatch($sformatf("read status %h, expected idle without errors", ctrl));
        end
        if (o_irq !== 1'b0) begin
            flag_mismatch("o_irq still high after REG_CTRL read");
        end
    endtask

    task automatic test_wrong_address();
        logic [31:0] ctrl;
        reg_write(REG_ADDR, addr_word(1'b0, 4'd1, 7'h21));
        wait_transfer_end();
        reg_read(REG_CTRL, ctrl);
        if (ctrl[9] !== 1'b1 || ctrl[10] !== 1'b0) begin
            flag_mismatch($sformatf("status %h, expected header error only", ctrl));
        end
        if (wr_count !== 4'd0) begin
            flag_mismatch($sformatf("slave recorded %0d bytes for a foreign address", wr_count));
        end
        reg_write(REG_CTRL, 32'h0000_1000);
        reg_read(REG_CTRL, ctrl);
        if (ctrl[10:9] !== 2'b00) begin
            flag_mismatch("error bits not cleared by REG_CTRL write");
        end
    endtask

    task automatic test_nreset();
        reg_write(REG_CTRL, 32'h0001_1000);
        if (o_nreset !== 1'b1) begin
            flag_mismatch("o_nreset not driven high by bit 16");
        end
        reg_write(REG_CTRL, 32'h0002_1000);
        if (o_nreset !== 1'b0) begin
            flag_mismatch("o_nreset not driven low by bit 17");
        end
    endtask

    initial begin
        i_nrst       = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_resp_ready = 1'b1;
        repeat (10) @(negedge i_clk);
        i_nrst = 1'b1;
        test_reset_state();
        test_backpressure();
        test_write_transfer();
        test_read_transfer();
        test_wrong_address();
        test_nreset();
        $display("Summary: %0d value mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb_i2c_slave_model.sv
`timescale 1ns/1ps

module tb_i2c_slave_model #(
    parameter logic [6:0]  SLAVE_ADDR = 7'h50,
    parameter logic [31:0] READ_DATA  = 32'hA53C_960F    // First byte sent in the top bits
) (
    input  logic        i_clk,          // Oversampling clock
    input  logic        i_scl,
    input  logic        i_sda,          // Resolved bus level
    output logic        o_sda,          // Low pulls the bus down
    output logic [3:0]  o_wr_count,
    output logic [31:0] o_wr_data,      // Byte n at bits 8n+7:8n
    output logic [3:0]  o_ack_count,
    output logic [3:0]  o_ack_bits      // Master ACK bit per read byte, 1 is NACK
);

    localparam int PH_IDLE  = 0;
    localparam int PH_ADDR  = 1;
    localparam int PH_WRITE = 2;
    localparam int PH_READ  = 3;

    int          phase   = PH_IDLE;
    int          bit_idx = 0;           // 0..7 data bits, 8 is the ACK slot
    int          rd_idx  = 0;
    int          wr_cnt  = 0;
    int          ack_cnt = 0;
    logic        scl_q   = 1'b1;
    logic        sda_q   = 1'b1;
    logic        match   = 1'b0;
    logic        rnw     = 1'b0;
    logic        drive   = 1'b1;
    logic [7:0]  sh      = 8'h00;
    logic [7:0]  rd_byte = 8'h00;
    logic [31:0] wr_data = 32'h0;
    logic [3:0]  ack_bits = 4'h0;

    assign o_sda       = drive;
    assign o_wr_count  = 4'(wr_cnt);
    assign o_wr_data   = wr_data;
    assign o_ack_count = 4'(ack_cnt);
    assign o_ack_bits  = ack_bits;

    // Bus lines only move on rising clock edges, so the falling edge sees them settled
    always @(negedge i_clk) begin
        if (scl_q && i_scl && sda_q && !i_sda) begin
            phase    = PH_ADDR;             // START, logs cover one transfer
            bit_idx  = 0;
            rd_idx   = 0;
            match    = 1'b0;
            drive    = 1'b1;
            wr_cnt   = 0;
            wr_data  = 32'h0;
            ack_cnt  = 0;
            ack_bits = 4'h0;
        end else if (scl_q && i_scl && !sda_q && i_sda) begin
            phase = PH_IDLE;                // STOP
            drive = 1'b1;
        end else if (!scl_q && i_scl && phase != PH_IDLE) begin
            if (bit_idx < 8) begin
                sh = {sh[6:0], i_sda};
            end
            if (bit_idx == 7 && phase == PH_ADDR) begin
                match = (sh[7:1] == SLAVE_ADDR);
                rnw   = sh[0];
            end
            if (bit_idx == 7 && phase == PH_WRITE && wr_cnt < 4) begin
                wr_data[wr_cnt*8 +: 8] = sh;
                wr_cnt = wr_cnt + 1;
            end
            if (bit_idx == 8) begin
                if (phase == PH_ADDR) begin
                    phase = !match ? PH_IDLE : (rnw ? PH_READ : PH_WRITE);
                end else if (phase == PH_READ && ack_cnt < 4) begin
                    ack_bits[ack_cnt] = i_sda;
                    ack_cnt = ack_cnt + 1;
                    rd_idx  = rd_idx + 1;
                    if (i_sda) begin
                        phase = PH_IDLE;    // Master NACK ends the read
                    end
                end
                bit_idx = 0;
            end else begin
                bit_idx = bit_idx + 1;
            end
        end else if (scl_q && !i_scl) begin
            drive = 1'b1;
            if (bit_idx == 8 && (phase == PH_WRITE || (phase == PH_ADDR && match))) begin
                drive = 1'b0;               // ACK slot
            end
            if (phase == PH_READ && bit_idx < 8 && rd_idx < 4) begin
                rd_byte = READ_DATA[31 - 8*rd_idx -: 8];
                drive   = rd_byte[7 - bit_idx];
            end
        end
        scl_q = i_scl;
        sda_q = i_sda;
    end

endmodule

// File: i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top import i2c_pkg::*; #(
    parameter int DIV_W = 16
) (
    input  logic      i_clk,
    input  logic      i_nrst,
    input  logic      i_req_valid,
    output logic      o_req_ready,
    input  reg_req_t  i_req,
    output logic      o_resp_valid,
    input  logic      i_resp_ready,
    output reg_resp_t o_resp,
    output logic      o_scl,
    output logic      o_sda,
    output logic      o_sda_oe,     // High while the master drives SDA
    input  logic      i_sda,
    output logic      o_irq,
    output logic      o_nreset      // Reset for the downstream slave mux
);

    logic [DIV_W-1:0] scaler;
    logic [DIV_W-1:0] setup;
    xfer_cfg_t        cfg;
    xfer_status_t     status;
    shift_op_e        op;
    logic             start, done, run;
    logic             change, latch;
    logic             pay_we;
    logic [31:0]      pay_wdata;
    logic [31:0]      payload;

    i2c_csr #(.DIV_W(DIV_W)) u_csr (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_resp_ready (i_resp_ready),
        .i_payload    (payload),
        .i_status     (status),
        .i_done       (done),
        .i_sda        (i_sda),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp),
        .o_scaler     (scaler),
        .o_setup      (setup),
        .o_cfg        (cfg),
        .o_start      (start),
        .o_pay_we     (pay_we),
        .o_pay_wdata  (pay_wdata),
        .o_irq        (o_irq),
        .o_nreset     (o_nreset)
    );

    i2c_scl_timer #(.DIV_W(DIV_W)) u_timer (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_scaler (scaler),
        .i_setup  (setup),
        .i_run    (run),
        .o_scl    (o_scl),
        .o_change (change),
        .o_latch  (latch)
    );

    i2c_byte_shifter u_shifter (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_op        (op),
        .i_cfg       (cfg),
        .i_latch     (latch),
        .i_sda       (i_sda),
        .i_pay_we    (pay_we),
        .i_pay_wdata (pay_wdata),
        .o_sda       (o_sda),
        .o_payload   (payload)
    );

    i2c_master_fsm u_fsm (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_start  (start),
        .i_cfg    (cfg),
        .i_change (change),
        .i_latch  (latch),
        .i_sda    (i_sda),
        .o_op     (op),
        .o_sda_oe (o_sda_oe),
        .o_run    (run),
        .o_done   (done),
        .o_status (status)
    );

endmodule

// File: i2c_csr.sv
`timescale 1ns/1ps

module i2c_csr import i2c_pkg::*; #(
    parameter int DIV_W = 16
) (
    input  logic             i_clk,
    input  logic             i_nrst,
    input  logic             i_req_valid,
    input  reg_req_t         i_req,
    input  logic             i_resp_ready,
    input  logic [31:0]      i_payload,
    input  xfer_status_t     i_status,
    input  logic             i_done,
    input  logic             i_sda,
    output logic             o_req_ready,
    output logic             o_resp_valid,
    output reg_resp_t        o_resp,
    output logic [DIV_W-1:0] o_scaler,
    output logic [DIV_W-1:0] o_setup,
    output xfer_cfg_t        o_cfg,
    output logic             o_start,
    output logic             o_pay_we,
    output logic [31:0]      o_pay_wdata,
    output logic             o_irq,
    output logic             o_nreset
);

    logic [DIV_W-1:0] scaler;
    logic [DIV_W-1:0] setup;
    xfer_cfg_t        cfg;
    logic             start;
    logic             ie, irq, nreset;
    logic             err_hdr, err_data;
    logic             resp_valid;
    logic [31:0]      resp_rdata;
    logic [31:0]      rdata;
    logic             accept;

    // One request in flight at most
    assign o_req_ready = !resp_valid || i_resp_ready;
    assign accept      = i_req_valid && o_req_ready;

    always_comb begin
        rdata = '0;
        case (i_req.addr)
            REG_SCLDIV: begin
                rdata[DIV_W-1:0]  = scaler;
                rdata[16 +: DIV_W] = setup;
            end
            REG_CTRL: begin
                rdata[3:0] = i_status.state;
                rdata[8]   = i_sda;
                rdata[9]   = err_hdr;
                rdata[10]  = err_data;
                rdata[12]  = ie;
                rdata[13]  = irq;
                rdata[16]  = nreset;
            end
            REG_ADDR: begin
                rdata[31]    = cfg.r_nw;
                rdata[19:16] = cfg.byte_cnt;
                rdata[6:0]   = cfg.addr;
            end
            REG_PAYLOAD: rdata = i_payload;
            default:     rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scaler     <= '0;
            setup      <= '0;
            cfg        <= '0;
            start      <= 1'b0;
            ie         <= 1'b0;
            irq        <= 1'b0;
            nreset     <= 1'b0;
            err_hdr    <= 1'b0;
            err_data   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                resp_valid <= 1'b1;
            end else if (i_resp_ready) begin
                resp_valid <= 1'b0;
            end
            if (accept && !i_req.write && i_req.addr == REG_CTRL) begin
                irq <= 1'b0;                        // Cleared by a CTRL read
            end
            if (accept && i_req.write) begin
                case (i_req.addr)
                    REG_SCLDIV: begin
                        scaler <= i_req.wdata[DIV_W-1:0];
                        setup  <= i_req.wdata[16 +: DIV_W];
                    end
                    REG_CTRL: begin
                        err_hdr  <= 1'b0;
                        err_data <= 1'b0;
                        ie       <= i_req.wdata[12];
                        if (i_req.wdata[16]) begin
                            nreset <= 1'b1;
                        end else if (i_req.wdata[17]) begin
                            nreset <= 1'b0;
                        end
                    end
                    REG_ADDR: begin
                        if (i_status.state == ST_IDLE && !start) begin   // Dropped while busy
                            cfg   <= '{addr: i_req.wdata[6:0], r_nw: i_req.wdata[31],
                                       byte_cnt: i_req.wdata[19:16]};
                            start <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            if (i_done) begin
                if (ie) begin
                    irq <= 1'b1;
                end
                err_hdr  <= err_hdr | i_status.err_hdr;
                err_data <= err_data | i_status.err_data;
            end
        end
    end

    // Read data captured before the write lands
    always_ff @(posedge i_clk) begin
        if (accept) begin
            resp_rdata <= rdata;
        end
    end

    assign o_resp_valid = resp_valid;
    assign o_resp       = '{rdata: resp_rdata, err: 1'b0};
    assign o_scaler     = scaler;
    assign o_setup      = setup;
    assign o_cfg        = cfg;
    assign o_start      = start;
    assign o_pay_we     = accept && i_req.write && (i_req.addr == REG_PAYLOAD);
    assign o_pay_wdata  = i_req.wdata;
    assign o_irq        = irq;
    assign o_nreset     = nreset;

endmodule

// File: i2c_master_fsm.sv
`timescale 1ns/1ps

module i2c_master_fsm import i2c_pkg::*; (
    input  logic         i_clk,
    input  logic         i_nrst,
    input  logic         i_start,
    input  xfer_cfg_t    i_cfg,
    input  logic         i_change,
    input  logic         i_latch,
    input  logic         i_sda,
    output shift_op_e    o_op,
    output logic         o_sda_oe,
    output logic         o_run,
    output logic         o_done,
    output xfer_status_t o_status
);

    fsm_state_e state, state_d;
    logic [2:0] bit_cnt, bit_cnt_d;
    logic [3:0] byte_cnt, byte_cnt_d;
    logic       ack, ack_d;
    logic       sda_oe, sda_oe_d;
    logic       err_hdr, err_hdr_d;
    logic       err_data, err_data_d;
    logic       done;
    shift_op_e  op;

    always_comb begin
        state_d    = state;
        bit_cnt_d  = bit_cnt;
        byte_cnt_d = byte_cnt;
        ack_d      = ack;
        sda_oe_d   = sda_oe;
        err_hdr_d  = err_hdr;
        err_data_d = err_data;
        op         = i_change ? SH_SHIFT : SH_NONE;

        case (state)
            ST_IDLE: begin
                op       = SH_DRIVE_HIGH;
                sda_oe_d = 1'b1;
                if (i_start) begin
                    op         = SH_LOAD_HDR;   // SDA falls while SCL high
                    byte_cnt_d = i_cfg.byte_cnt;
                    err_hdr_d  = 1'b0;
                    err_data_d = 1'b0;
                    state_d    = ST_START;
                end
            end
            ST_START: begin
                if (i_change) begin
                    bit_cnt_d = 3'd7;
                    state_d   = ST_HEADER;
                end
            end
            ST_HEADER: begin
                if (i_change) begin
                    if (bit_cnt == 3'd0) begin
                        sda_oe_d = 1'b0;         // Release for slave ACK
                        state_d  = ST_ACK_HEADER;
                    end else begin
                        bit_cnt_d = bit_cnt - 1'b1;
                    end
                end
            end
            ST_ACK_HEADER: begin
                if (i_latch) begin
                    ack_d = i_sda;
                end
                if (i_change) begin
                    if (ack || byte_cnt == 4'd0) begin
                        err_hdr_d = ack;
                        op        = SH_DRIVE_LOW;
                        sda_oe_d  = 1'b1;
                        state_d   = ST_STOP;
                    end else begin
                        bit_cnt_d = 3'd7;
                        sda_oe_d  = ~i_cfg.r_nw;
                        state_d   = i_cfg.r_nw ? ST_RX_DATA : ST_TX_DATA;
                    end
                end
            end
            ST_TX_DATA: begin
                if (i_change) begin
                    if (bit_cnt == 3'd0) begin
                        op         = SH_DRIVE_LOW;   // Low ahead of a possible STOP
                        sda_oe_d   = 1'b0;
                        byte_cnt_d = byte_cnt - 1'b1;
                        state_d    = ST_WAIT_ACK_DATA;
                    end else begin
                        bit_cnt_d = bit_cnt - 1'b1;
                    end
                end
            end
            ST_WAIT_ACK_DATA: begin
                if (i_latch) begin
                    ack_d = i_sda;
                end
                if (i_change) begin
                    sda_oe_d = 1'b1;
                    if (ack || byte_cnt == 4'd0) begin
                        err_data_d = ack;
                        op         = SH_DRIVE_LOW;
                        state_d    = ST_STOP;
                    end else begin
                        bit_cnt_d = 3'd7;
                        op        = SH_LOAD_DATA;
                        state_d   = ST_TX_DATA;
                    end
                end
            end
            ST_RX_DATA: begin
                if (i_change) begin
                    if (bit_cnt == 3'd0) begin
                        sda_oe_d   = 1'b1;
                        byte_cnt_d = byte_cnt - 1'b1;
                        // Last byte gets NACK
                        op         = (byte_cnt > 4'd1) ? SH_DRIVE_LOW : SH_DRIVE_HIGH;
                        state_d    = ST_ACK_DATA;
                    end else begin
                        bit_cnt_d = bit_cnt - 1'b1;
                    end
                end
            end
            ST_ACK_DATA: begin
                if (i_latch) begin
                    op = SH_PUSH_RX;      // rx_byte still holds the 8 data bits
                end
                if (i_change) begin
                    if (byte_cnt == 4'd0) begin
                        op      = SH_DRIVE_LOW;
                        state_d = ST_STOP;
                    end else begin
                        bit_cnt_d = 3'd7;
                        sda_oe_d  = 1'b0;
                        op        = SH_DRIVE_HIGH;
                        state_d   = ST_RX_DATA;
                    end
                end
            end
            ST_STOP: begin
                if (i_latch) begin
                    op      = SH_DRIVE_HIGH;    // SDA rises while SCL high
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            ack      <= 1'b1;
            sda_oe   <= 1'b1;
            err_hdr  <= 1'b0;
            err_data <= 1'b0;
            done     <= 1'b0;
        end else begin
            state    <= state_d;
            bit_cnt  <= bit_cnt_d;
            byte_cnt <= byte_cnt_d;
            ack      <= ack_d;
            sda_oe   <= sda_oe_d;
            err_hdr  <= err_hdr_d;
            err_data <= err_data_d;
            done     <= (state == ST_STOP) && i_latch;
        end
    end

    assign o_op     = op;
    assign o_sda_oe = sda_oe;
    assign o_run    = (state != ST_IDLE);
    assign o_done   = done;
    assign o_status = '{state: state, err_hdr: err_hdr, err_data: err_data};

    // The register block holds back starts while a transfer runs
    a_start_only_idle: assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_start |-> state == ST_IDLE)
        else $error("start seen while busy");

    // A wrap from 0 to 7 must be a reload, never a decrement
    a_bit_cnt_no_underflow: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        ($past(bit_cnt) == 3'd0 && bit_cnt == 3'd7) |->
        ($past(state) inside {ST_START, ST_ACK_HEADER, ST_WAIT_ACK_DATA, ST_ACK_DATA}))
        else $error("bit counter underflow");

endmodule

// File: i2c_byte_shifter.sv
`timescale 1ns/1ps

module i2c_byte_shifter import i2c_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  shift_op_e   i_op,
    input  xfer_cfg_t   i_cfg,
    input  logic        i_latch,
    input  logic        i_sda,
    input  logic        i_pay_we,
    input  logic [31:0] i_pay_wdata,
    output logic        o_sda,
    output logic [31:0] o_payload
);

    logic [18:0] shreg;      // MSB is the line value
    logic [7:0]  rx_byte;
    logic [31:0] payload;

    assign o_sda     = shreg[18];
    assign o_payload = payload;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            shreg <= '1;
        end else begin
            case (i_op)
                SH_LOAD_HDR:   shreg <= {1'b0, i_cfg.addr, i_cfg.r_nw, 1'b0, payload[7:0], 1'b1};
                SH_LOAD_DATA:  shreg <= {payload[7:0], 11'h7FF};
                SH_SHIFT:      shreg <= {shreg[17:0], 1'b1};
                SH_DRIVE_LOW:  shreg <= '0;
                SH_DRIVE_HIGH: shreg <= '1;
                default:       shreg <= shreg;
            endcase
        end
    end

    // Receive bits arrive MSB first
    always_ff @(posedge i_clk) begin
        if (i_latch) begin
            rx_byte <= {rx_byte[6:0], i_sda};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_pay_we) begin
            payload <= i_pay_wdata;                 // Host write has priority
        end else begin
            case (i_op)
                SH_LOAD_HDR,
                SH_LOAD_DATA: payload <= {8'd0, payload[31:8]};    // Pop low byte
                SH_PUSH_RX:   payload <= {payload[23:0], rx_byte};
                default:      payload <= payload;
            endcase
        end
    end

endmodule

// File: i2c_scl_timer.sv
`timescale 1ns/1ps

module i2c_scl_timer #(
    parameter int DIV_W = 16
) (
    input  logic             i_clk,
    input  logic             i_nrst,
    input  logic [DIV_W-1:0] i_scaler,   // Cycles per SCL half period
    input  logic [DIV_W-1:0] i_setup,    // Strobe point inside each half
    input  logic             i_run,
    output logic             o_scl,
    output logic             o_change,
    output logic             o_latch
);

    logic [DIV_W-1:0] cnt;
    logic             level;
    logic             active;
    logic             wrap;
    logic             at_setup;

    assign active   = i_run && (i_scaler != '0);
    assign wrap     = (cnt == i_scaler - 1'b1);
    assign at_setup = active && !wrap && (cnt == i_setup);

    // SDA may only move while SCL is low
    assign o_change = at_setup && !level;
    assign o_latch  = at_setup && level;
    assign o_scl    = level;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt   <= '0;
            level <= 1'b1;
        end else if (!i_run) begin
            cnt   <= '0;           // Bus idle, SCL parked high
            level <= 1'b1;
        end else if (i_scaler != '0) begin
            if (wrap) begin
                cnt   <= '0;
                level <= ~level;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Each strobe lasts a single clock
    a_strobes_single: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_change || o_latch) |=> !(o_change || o_latch))
        else $error("strobe longer than one cycle");

endmodule

// File: i2c_pkg.sv
package i2c_pkg;

    // Register word offsets
    localparam logic [1:0] REG_SCLDIV  = 2'd0;   // Divider and setup point
    localparam logic [1:0] REG_CTRL    = 2'd1;   // Control and status
    localparam logic [1:0] REG_ADDR    = 2'd2;   // Slave address, direction, count
    localparam logic [1:0] REG_PAYLOAD = 2'd3;   // Up to four data bytes

    typedef enum logic [3:0] {
        ST_IDLE          = 4'd0,
        ST_START         = 4'd1,
        ST_HEADER        = 4'd2,
        ST_ACK_HEADER    = 4'd3,
        ST_TX_DATA       = 4'd4,
        ST_WAIT_ACK_DATA = 4'd5,
        ST_RX_DATA       = 4'd6,
        ST_ACK_DATA      = 4'd7,
        ST_STOP          = 4'd8
    } fsm_state_e;

    // Shift register commands issued by the FSM
    typedef enum logic [2:0] {
        SH_NONE       = 3'd0,
        SH_LOAD_HDR   = 3'd1,
        SH_LOAD_DATA  = 3'd2,
        SH_SHIFT      = 3'd3,
        SH_DRIVE_LOW  = 3'd4,
        SH_DRIVE_HIGH = 3'd5,
        SH_PUSH_RX    = 3'd6
    } shift_op_e;

    typedef struct packed {
        logic [1:0]  addr;
        logic        write;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } reg_resp_t;

    typedef struct packed {
        logic [6:0] addr;
        logic       r_nw;
        logic [3:0] byte_cnt;
    } xfer_cfg_t;

    typedef struct packed {
        fsm_state_e state;
        logic       err_hdr;
        logic       err_data;
    } xfer_status_t;

endpackage
